/* alloc_pkg.sv */
package alloc_pkg;

	localparam int DATA_W = 32;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [4:0] gr_ptr_t;

	// Opaque to this stage, decoded by execute
	typedef logic [4:0] cmd_t;

	typedef enum logic [4:0] {
		SYSREG_PSR  = 5'd0,
		SYSREG_SPR  = 5'd1,
		SYSREG_IDTR = 5'd2,
		SYSREG_PPSR = 5'd3
	} sysreg_id_t;

	// Status bits dropped on interrupt entry (6, 5 and 2)
	localparam data_t PSR_IRQ_CLEAR_MASK = 32'h0000_0064;

	// Register view of source 1
	typedef struct packed {
		logic [DATA_W-$bits(gr_ptr_t)-1:0] pad;
		gr_ptr_t ptr;
	} src1_reg_t;

	// Source 1 is an immediate or a register pointer
	typedef union packed {
		data_t imm;
		src1_reg_t rv;
	} src1_word_u;

endpackage

/* alloc_if.sv */
interface wb_if;
	import alloc_pkg::*;

	logic wb_valid;
	gr_ptr_t wb_dest;
	logic wb_dest_sysreg;
	logic wb_writeback;
	data_t wb_data;
	logic wb_spr_writeback;
	data_t wb_spr;

	modport sink (
		input wb_valid,
		input wb_dest,
		input wb_dest_sysreg,
		input wb_writeback,
		input wb_data,
		input wb_spr_writeback,
		input wb_spr
	);

endinterface

interface src_read_if;
	import alloc_pkg::*;

	gr_ptr_t ptr0;
	gr_ptr_t ptr1;
	data_t data0;
	data_t data1;
	logic hit0;
	logic hit1;

	modport requester (
		output ptr0,
		output ptr1,
		input data0,
		input data1,
		input hit0,
		input hit1
	);

	modport provider (
		input ptr0,
		input ptr1,
		output data0,
		output data1,
		output hit0,
		output hit1
	);

endinterface

/* general_register_file.sv */
module general_register_file #(
	parameter int GR_COUNT = 32
) (
	input logic iCLOCK,
	input logic inRESET,
	wb_if.sink wb,
	src_read_if.provider rd
);
	import alloc_pkg::*;

	data_t regs [GR_COUNT];
	logic wb_gr;
	logic wr_en;

	// Writeback aimed at the general registers
	assign wb_gr = wb.wb_valid && wb.wb_writeback && !wb.wb_dest_sysreg;

	// No array update while reset is held
	assign wr_en = inRESET && wb_gr;

	always_ff @(posedge iCLOCK) begin
		if (wr_en) begin
			regs[wb.wb_dest] <= wb.wb_data;
		end
	end

	function automatic logic [DATA_W:0] read_port(input gr_ptr_t ptr);
		logic [DATA_W:0] res;
		if (wb_gr && wb.wb_dest == ptr) begin
			// Same-cycle writeback wins over the stored value
			res = {1'b1, wb.wb_data};
		end else begin
			res = {1'b0, regs[ptr]};
		end
		return res;
	endfunction

	always_comb begin
		{rd.hit0, rd.data0} = read_port(rd.ptr0);
		{rd.hit1, rd.data1} = read_port(rd.ptr1);
	end

endmodule

/* system_register_bank.sv */
module system_register_bank (
	input logic iCLOCK,
	input logic inRESET,
	input logic irq_enter,
	input logic irq_return,
	wb_if.sink wb,
	src_read_if.provider rd,
	output alloc_pkg::data_t psr,
	output alloc_pkg::data_t ppsr,
	output alloc_pkg::data_t spr,
	output alloc_pkg::data_t idtr
);
	import alloc_pkg::*;

	logic sys_wr;
	logic spr_load;
	logic wr_psr;
	logic wr_ppsr;
	logic wr_spr;
	logic wr_idtr;

	assign sys_wr = wb.wb_valid && wb.wb_writeback && wb.wb_dest_sysreg;
	assign spr_load = wb.wb_valid && wb.wb_spr_writeback;

	assign wr_psr = sys_wr && (wb.wb_dest == SYSREG_PSR);
	assign wr_ppsr = sys_wr && (wb.wb_dest == SYSREG_PPSR);
	assign wr_spr = sys_wr && (wb.wb_dest == SYSREG_SPR);
	assign wr_idtr = sys_wr && (wb.wb_dest == SYSREG_IDTR);

	// Interrupt swaps take priority over writeback
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			psr <= '0;
		end else if (irq_enter) begin
			psr <= psr & ~PSR_IRQ_CLEAR_MASK;
		end else if (irq_return) begin
			psr <= ppsr;
		end else if (wr_psr) begin
			psr <= wb.wb_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			ppsr <= '0;
		end else if (irq_enter) begin
			ppsr <= psr;
		end else if (wr_ppsr) begin
			ppsr <= wb.wb_data;
		end
	end

	// Stack pointer update from the load/store path beats a plain write
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			spr <= '0;
		end else if (spr_load) begin
			spr <= wb.wb_spr;
		end else if (wr_spr) begin
			spr <= wb.wb_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			idtr <= '0;
		end else if (wr_idtr) begin
			idtr <= wb.wb_data;
		end
	end

	function automatic logic [DATA_W:0] read_port(input gr_ptr_t id);
		logic [DATA_W:0] res;
		case (sysreg_id_t'(id))
			SYSREG_PSR: res = {1'b1, psr};
			SYSREG_SPR: res = {1'b1, spr};
			SYSREG_IDTR: res = {1'b1, idtr};
			SYSREG_PPSR: res = {1'b1, ppsr};
			default: res = '0;
		endcase
		if (spr_load && id == SYSREG_SPR) begin
			res = {1'b1, wb.wb_spr};
		end else if (res[DATA_W] && sys_wr && wb.wb_dest == id) begin
			res = {1'b1, wb.wb_data};
		end
		return res;
	endfunction

	always_comb begin
		{rd.hit0, rd.data0} = read_port(rd.ptr0);
		{rd.hit1, rd.data1} = read_port(rd.ptr1);
	end

endmodule

/* operand_latch.sv */
module operand_latch (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic in_valid,
	output logic in_ready,
	input alloc_pkg::gr_ptr_t in_src0_ptr,
	input logic in_src0_sysreg,
	input logic in_src1_sysreg,
	input logic in_src1_imm,
	input alloc_pkg::src1_word_u in_src1,
	input alloc_pkg::cmd_t in_cmd,
	input alloc_pkg::gr_ptr_t in_dest,
	input alloc_pkg::data_t in_pc,
	output logic out_valid,
	input logic out_ready,
	output alloc_pkg::data_t out_src0,
	output alloc_pkg::data_t out_src1,
	output alloc_pkg::cmd_t out_cmd,
	output alloc_pkg::gr_ptr_t out_dest,
	output alloc_pkg::data_t out_pc,
	src_read_if.requester gr,
	src_read_if.requester sys
);
	import alloc_pkg::*;

	logic accept;
	data_t src0_sel;
	data_t src1_sel;

	// Both readers look at the same pointers
	assign gr.ptr0 = in_src0_ptr;
	assign gr.ptr1 = in_src1.rv.ptr;
	assign sys.ptr0 = in_src0_ptr;
	assign sys.ptr1 = in_src1.rv.ptr;

	function automatic data_t pick_operand(
		input logic use_sys,
		input logic sys_hit,
		input data_t sys_data,
		input data_t gr_data
	);
		data_t res;
		if (use_sys) begin
			// unknown system register reads as zero
			res = sys_hit ? sys_data : '0;
		end else begin
			res = gr_data;
		end
		return res;
	endfunction

	always_comb begin
		src0_sel = pick_operand(in_src0_sysreg, sys.hit0, sys.data0, gr.data0);
		if (in_src1_imm) begin
			src1_sel = in_src1.imm;
		end else begin
			src1_sel = pick_operand(in_src1_sysreg, sys.hit1, sys.data1, gr.data1);
		end
	end

	// Free slot, or the held one leaves this cycle
	assign in_ready = !out_valid || out_ready;
	assign accept = in_valid && in_ready;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0;
		end else if (accept) begin
			out_valid <= 1'b1;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			out_src0 <= src0_sel;
			out_src1 <= src1_sel;
			out_cmd <= in_cmd;
			out_dest <= in_dest;
			out_pc <= in_pc;
		end
	end

endmodule

/* register_allocate.sv */
module register_allocate #(
	parameter int GR_COUNT = 32
) (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic irq_enter,
	input logic irq_return,
	input logic in_valid,
	output logic in_ready,
	input alloc_pkg::gr_ptr_t in_src0_ptr,
	input logic in_src0_sysreg,
	input logic in_src1_sysreg,
	input logic in_src1_imm,
	input alloc_pkg::src1_word_u in_src1,
	input alloc_pkg::cmd_t in_cmd,
	input alloc_pkg::gr_ptr_t in_dest,
	input alloc_pkg::data_t in_pc,
	output logic out_valid,
	input logic out_ready,
	output alloc_pkg::data_t out_src0,
	output alloc_pkg::data_t out_src1,
	output alloc_pkg::cmd_t out_cmd,
	output alloc_pkg::gr_ptr_t out_dest,
	output alloc_pkg::data_t out_pc,
	output alloc_pkg::data_t psr,
	output alloc_pkg::data_t ppsr,
	output alloc_pkg::data_t spr,
	output alloc_pkg::data_t idtr,
	input logic wb_valid,
	input logic wb_dest_sysreg,
	input logic wb_writeback,
	input logic wb_spr_writeback,
	input alloc_pkg::gr_ptr_t wb_dest,
	input alloc_pkg::data_t wb_data,
	input alloc_pkg::data_t wb_spr
);

	wb_if wb ();
	src_read_if gr_rd ();
	src_read_if sys_rd ();

	// Writeback bundle shared by both register stores
	assign wb.wb_valid = wb_valid;
	assign wb.wb_dest = wb_dest;
	assign wb.wb_dest_sysreg = wb_dest_sysreg;
	assign wb.wb_writeback = wb_writeback;
	assign wb.wb_data = wb_data;
	assign wb.wb_spr_writeback = wb_spr_writeback;
	assign wb.wb_spr = wb_spr;

	general_register_file #(
		.GR_COUNT(GR_COUNT)
	) u_grf (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.wb(wb),
		.rd(gr_rd)
	);

	system_register_bank u_sysreg (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.irq_enter(irq_enter),
		.irq_return(irq_return),
		.wb(wb),
		.rd(sys_rd),
		.psr(psr),
		.ppsr(ppsr),
		.spr(spr),
		.idtr(idtr)
	);

	operand_latch u_latch (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.flush(flush),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_src0_ptr(in_src0_ptr),
		.in_src0_sysreg(in_src0_sysreg),
		.in_src1_sysreg(in_src1_sysreg),
		.in_src1_imm(in_src1_imm),
		.in_src1(in_src1),
		.in_cmd(in_cmd),
		.in_dest(in_dest),
		.in_pc(in_pc),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_src0(out_src0),
		.out_src1(out_src1),
		.out_cmd(out_cmd),
		.out_dest(out_dest),
		.out_pc(out_pc),
		.gr(gr_rd),
		.sys(sys_rd)
	);

endmodule

/* register_allocate_sva.sv */
module register_allocate_sva (
	input logic iCLOCK,
	input logic inRESET,
	input logic flush,
	input logic in_valid,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input alloc_pkg::data_t out_src0,
	input alloc_pkg::data_t out_src1,
	input alloc_pkg::cmd_t out_cmd,
	input alloc_pkg::gr_ptr_t out_dest,
	input alloc_pkg::data_t out_pc
);

	// Output register stays empty while reset is held
	assert property (@(posedge iCLOCK) !inRESET |-> !out_valid)
		else $error("out_valid high during reset");

	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_valid && !out_ready |=> $stable({out_src0, out_src1, out_cmd, out_dest, out_pc}))
		else $error("held output changed under back-pressure");

	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		out_valid && !out_ready && !flush |=> out_valid)
		else $error("held output dropped without out_ready or flush");

	// A ready input slot really takes the instruction
	assert property (@(posedge iCLOCK) disable iff (!inRESET)
		in_valid && in_ready && !flush |=> out_valid)
		else $error("instruction taken while in_ready was high did not reach the output");

endmodule

bind register_allocate register_allocate_sva u_sva (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.flush(flush),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_src0(out_src0),
	.out_src1(out_src1),
	.out_cmd(out_cmd),
	.out_dest(out_dest),
	.out_pc(out_pc)
);

/* tb_register_allocate.sv */
module tb_register_allocate;
	import alloc_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int WAIT_LIMIT = 20;
	// Rough cycles per test, in run order
	localparam int TEST_CYCLES = 10 + 6 + 6 + 14 + 10 + 20;
	localparam int MARGIN_CYCLES = 50;

	logic iCLOCK, inRESET, flush, irq_enter, irq_return;
	logic in_valid, in_ready, in_src0_sysreg, in_src1_sysreg, in_src1_imm;
	logic out_valid, out_ready;
	logic wb_valid, wb_dest_sysreg, wb_writeback, wb_spr_writeback;
	gr_ptr_t in_src0_ptr, in_dest, out_dest, wb_dest;
	src1_word_u in_src1;
	cmd_t in_cmd, out_cmd;
	data_t in_pc, out_src0, out_src1, out_pc, psr, ppsr, spr, idtr, wb_data, wb_spr;
	integer seed = 32'hf910_7a11;
	int errors = 0;
	int tests = 0;

	register_allocate #(.GR_COUNT(32)) DUT (.*);

	initial begin
		iCLOCK = 1'b0;
		forever #(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
	end

	initial begin
		#((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("test failed");
		$finish;
	end

	task automatic compare_data(input string name, input data_t exp, input data_t act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_cmd(input string name, input cmd_t exp, input cmd_t act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_ptr(input string name, input gr_ptr_t exp, input gr_ptr_t act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic compare_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests++;
		$display("%s finished with %0d mismatches", name, errors - errs_before);
	endtask

	function automatic src1_word_u reg_word(input gr_ptr_t p);
		src1_word_u w;
		w.rv.pad = '0;
		w.rv.ptr = p;
		return w;
	endfunction

	task automatic wb_drive(input logic sys, input gr_ptr_t dest, input data_t d);
		wb_valid = 1'b1;
		wb_writeback = 1'b1;
		wb_dest_sysreg = sys;
		wb_dest = dest;
		wb_data = d;
	endtask

	task automatic wb_idle();
		wb_valid = 1'b0;
		wb_writeback = 1'b0;
		wb_spr_writeback = 1'b0;
	endtask

	task automatic write_back(input logic sys, input gr_ptr_t dest, input data_t d);
		wb_drive(sys, dest, d);
		@(posedge iCLOCK);
		#1;
		wb_idle();
	endtask

	// Holds the instruction on the inputs until the accept edge
	task automatic issue(input gr_ptr_t s0_ptr, input logic s0_sys, input src1_word_u s1,
			input logic s1_sys, input logic s1_imm, input cmd_t cmd, input gr_ptr_t dest,
			input data_t pc);
		int waited;
		waited = 0;
		in_src0_ptr = s0_ptr;
		in_src0_sysreg = s0_sys;
		in_src1 = s1;
		in_src1_sysreg = s1_sys;
		in_src1_imm = s1_imm;
		in_cmd = cmd;
		in_dest = dest;
		in_pc = pc;
		in_valid = 1'b1;
		@(negedge iCLOCK);
		while (!in_ready && waited < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (!in_ready) begin
			$display("instruction at pc %h was never accepted", pc);
			errors++;
		end
		@(posedge iCLOCK);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic check_out(input data_t s0, input data_t s1, input cmd_t cmd,
			input gr_ptr_t dest, input data_t pc);
		int waited;
		waited = 0;
		@(negedge iCLOCK);
		while (!out_valid && waited < WAIT_LIMIT) begin
			@(negedge iCLOCK);
			waited++;
		end
		if (!out_valid) begin
			$display("no result came out for pc %h", pc);
			errors++;
		end else begin
			compare_data("out_src0", s0, out_src0);
			compare_data("out_src1", s1, out_src1);
			compare_cmd("out_cmd", cmd, out_cmd);
			compare_ptr("out_dest", dest, out_dest);
			compare_data("out_pc", pc, out_pc);
		end
		@(posedge iCLOCK);
		#1;
	endtask

	task automatic test_gr_read();
		int e;
		data_t v [4];
		gr_ptr_t p [4];
		e = errors;
		p = '{5'd3, 5'd9, 5'd17, 5'd30};
		foreach (v[i]) begin
			v[i] = $random(seed);
			write_back(1'b0, p[i], v[i]);
		end
		issue(p[1], 1'b0, reg_word(p[3]), 1'b0, 1'b0, 5'h0a, 5'd4, 32'h100);
		check_out(v[1], v[3], 5'h0a, 5'd4, 32'h100);
		finish_test("gr_read", e);
	endtask

	task automatic test_forward();
		int e;
		data_t old_v;
		data_t new_v;
		e = errors;
		old_v = $random(seed);
		new_v = ~old_v;
		write_back(1'b0, 5'd12, old_v);
		wb_drive(1'b0, 5'd12, new_v);
		issue(5'd12, 1'b0, reg_word(5'd12), 1'b0, 1'b0, 5'h11, 5'd1, 32'h104);
		wb_idle();
		check_out(new_v, new_v, 5'h11, 5'd1, 32'h104);
		finish_test("forward", e);
	endtask

	task automatic test_imm();
		int e;
		data_t imm;
		data_t x;
		e = errors;
		// Low bits of the immediate alias register 7
		imm = ($random(seed) & ~32'h1f) | 32'd7;
		x = $random(seed);
		wb_drive(1'b0, 5'd7, x);
		issue(5'd7, 1'b0, src1_word_u'(imm), 1'b0, 1'b1, 5'h05, 5'd8, 32'h108);
		wb_idle();
		check_out(x, imm, 5'h05, 5'd8, 32'h108);
		finish_test("immediate", e);
	endtask

	task automatic test_sysreg();
		int e;
		data_t v [4];
		e = errors;
		foreach (v[i]) begin
			v[i] = $random(seed);
		end
		write_back(1'b1, SYSREG_PSR, v[0]);
		compare_data("psr", v[0], psr);
		write_back(1'b1, SYSREG_IDTR, v[1]);
		compare_data("idtr", v[1], idtr);
		write_back(1'b1, SYSREG_PPSR, v[2]);
		compare_data("ppsr", v[2], ppsr);
		wb_valid = 1'b1;
		wb_spr_writeback = 1'b1;
		wb_spr = v[3];
		@(posedge iCLOCK);
		#1;
		wb_idle();
		compare_data("spr", v[3], spr);
		issue(SYSREG_PSR, 1'b1, reg_word(SYSREG_IDTR), 1'b1, 1'b0, 5'h12, 5'd2, 32'h110);
		check_out(v[0], v[1], 5'h12, 5'd2, 32'h110);
		issue(SYSREG_PPSR, 1'b1, reg_word(SYSREG_SPR), 1'b1, 1'b0, 5'h13, 5'd3, 32'h114);
		check_out(v[2], v[3], 5'h13, 5'd3, 32'h114);
		issue(5'd9, 1'b1, reg_word(5'd20), 1'b1, 1'b0, 5'h14, 5'd5, 32'h118);
		check_out('0, '0, 5'h14, 5'd5, 32'h118);
		finish_test("sysreg", e);
	endtask

	task automatic test_irq();
		int e;
		data_t old_psr;
		e = errors;
		old_psr = $random(seed) | 32'h0000_0064;
		write_back(1'b1, SYSREG_PSR, old_psr);
		irq_enter = 1'b1;
		@(posedge iCLOCK);
		#1;
		irq_enter = 1'b0;
		compare_data("ppsr", old_psr, ppsr);
		compare_data("psr", old_psr & ~((32'd1 << 6) | (32'd1 << 5) | (32'd1 << 2)), psr);
		write_back(1'b1, SYSREG_PSR, ~old_psr);
		irq_return = 1'b1;
		@(posedge iCLOCK);
		#1;
		irq_return = 1'b0;
		compare_data("psr", old_psr, psr);
		finish_test("irq_swap", e);
	endtask

	task automatic test_backpressure();
		int e;
		data_t r5;
		data_t a;
		data_t b;
		e = errors;
		r5 = $random(seed);
		a = $random(seed);
		b = $random(seed);
		write_back(1'b0, 5'd5, r5);
		out_ready = 1'b0;
		issue(5'd5, 1'b0, src1_word_u'(a), 1'b0, 1'b1, 5'h01, 5'd2, 32'h200);
		// Second instruction waits behind the held one
		in_src1 = src1_word_u'(b);
		in_cmd = 5'h02;
		in_pc = 32'h204;
		in_valid = 1'b1;
		repeat (3) begin
			@(negedge iCLOCK);
			compare_bit("out_valid", 1'b1, out_valid);
			compare_bit("in_ready", 1'b0, in_ready);
			compare_data("out_src1", a, out_src1);
			compare_data("out_pc", 32'h200, out_pc);
		end
		@(posedge iCLOCK);
		#1;
		out_ready = 1'b1;
		@(negedge iCLOCK);
		compare_bit("in_ready", 1'b1, in_ready);
		compare_data("out_src1", a, out_src1);
		@(posedge iCLOCK);
		#1;
		in_valid = 1'b0;
		@(negedge iCLOCK);
		compare_bit("out_valid", 1'b1, out_valid);
		compare_data("out_src0", r5, out_src0);
		compare_data("out_src1", b, out_src1);
		compare_data("out_pc", 32'h204, out_pc);
		@(posedge iCLOCK);
		#1;
		out_ready = 1'b0;
		issue(5'd5, 1'b0, src1_word_u'(r5), 1'b0, 1'b1, 5'h03, 5'd6, 32'h208);
		@(negedge iCLOCK);
		compare_bit("out_valid", 1'b1, out_valid);
		@(posedge iCLOCK);
		#1;
		flush = 1'b1;
		@(posedge iCLOCK);
		#1;
		flush = 1'b0;
		@(negedge iCLOCK);
		compare_bit("out_valid", 1'b0, out_valid);
		@(posedge iCLOCK);
		#1;
		out_ready = 1'b1;
		finish_test("backpressure_flush", e);
	endtask

	initial begin
		inRESET = 1'b0;
		flush = 1'b0;
		irq_enter = 1'b0;
		irq_return = 1'b0;
		in_valid = 1'b0;
		in_src0_ptr = '0;
		in_src0_sysreg = 1'b0;
		in_src1_sysreg = 1'b0;
		in_src1_imm = 1'b0;
		in_src1 = '0;
		in_cmd = '0;
		in_dest = '0;
		in_pc = '0;
		out_ready = 1'b1;
		wb_valid = 1'b0;
		wb_dest_sysreg = 1'b0;
		wb_writeback = 1'b0;
		wb_spr_writeback = 1'b0;
		wb_dest = '0;
		wb_data = '0;
		wb_spr = '0;
		repeat (RESET_CYCLES) @(posedge iCLOCK);
		#1;
		inRESET = 1'b1;
		test_gr_read();
		test_forward();
		test_imm();
		test_sysreg();
		test_irq();
		test_backpressure();
		$display("%0d tests run, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* project.f */
alloc_pkg.sv
alloc_if.sv
general_register_file.sv
system_register_bank.sv
operand_latch.sv
register_allocate.sv
register_allocate_sva.sv
tb_register_allocate.sv
